// ==== include/bp_macros.svh ====
// ======================================
// Predictor sizing. BP_PC_BIT must equal BP_GHT_BIT
// BP_OBQ_DEPTH is the number of unresolved branches
// ======================================
`ifndef BP_MACROS_SVH
`define BP_MACROS_SVH

// Global history length and pattern table index width
`define BP_GHT_BIT 4

// PC bits hashed from bit 2 upward past the byte offset
`define BP_PC_BIT `BP_GHT_BIT

// Outstanding branch queue entries
`define BP_OBQ_DEPTH 8

`endif

// ==== src/bp_pkg.sv ====
// ======================================
// Shared predictor types sized from the macros header
// ======================================
`include "bp_macros.svh"

package bp_pkg;

	// Global history with the newest outcome in bit 0
	typedef logic [`BP_GHT_BIT-1:0] ghist_t;

	// Pattern table index from history XOR PC bits
	typedef logic [`BP_GHT_BIT-1:0] pht_idx_t;

	// Instruction address
	typedef logic [31:0] pc_t;

	// Queue occupancy wide enough to reach BP_OBQ_DEPTH
	typedef logic [$clog2(`BP_OBQ_DEPTH + 1)-1:0] obq_count_t;

endpackage

// ==== src/branch_request_stage.sv ====
// ======================================
// One-entry input register for branch PCs
// Accepts while its entry leaves; flush drops it
// ======================================
`timescale 1ns/10ps

module branch_request_stage
	import bp_pkg::*;
(
	input  logic clock,
	input  logic reset,
	input  logic flush,      // Mispredict drops the pending PC
	input  logic req_valid,
	input  pc_t  req_pc,
	output logic req_ready,
	output logic stage_valid,
	output pc_t  stage_pc,
	input  logic stage_take  // Lookup fires on the held PC
);

	logic accept_en; // Low in the reset cycle itself
	logic req_fire;

	always_ff @(posedge clock) begin
		if (reset) begin
			accept_en <= 1'b0;
		end else begin
			accept_en <= 1'b1;
		end
	end

	// Ready when empty or emptying but never during a flush
	assign req_ready = accept_en && !flush && (!stage_valid || stage_take);
	assign req_fire  = req_valid && req_ready;

	always_ff @(posedge clock) begin
		if (reset) begin
			stage_valid <= 1'b0;
		end else if (flush) begin
			stage_valid <= 1'b0;
		end else if (req_fire) begin
			stage_valid <= 1'b1; // Refill in the same cycle as a take
		end else if (stage_take) begin
			stage_valid <= 1'b0;
		end
	end

	always_ff @(posedge clock) begin
		if (req_fire) begin
			stage_pc <= req_pc;
		end
	end

endmodule

// ==== src/gshare_core.sv ====
// ======================================
// Gshare with a one-bit pattern table
// Table bit flips on mispredict, no counters
// ======================================
`timescale 1ns/10ps
`include "bp_macros.svh"

module gshare_core
	import bp_pkg::*;
(
	input  logic     clock,
	input  logic     reset,
	input  logic     lookup_fire,  // Branch leaves the request stage
	input  pc_t      lookup_pc,
	output pht_idx_t lookup_idx,   // Hash used and kept for repair
	output ghist_t   lookup_hist,  // History before this branch
	output logic     lookup_taken, // Guess where 1 is taken
	input  logic     mispredict,
	input  pht_idx_t fix_idx,
	input  ghist_t   fix_hist,     // Snapshot of the wrong branch
	input  logic     fix_taken     // Real outcome
);

	localparam int unsigned PHT_SIZE = 2 ** `BP_GHT_BIT;

	ghist_t                ghist;
	logic [PHT_SIZE-1:0]   pht;       // 0 not taken, 1 taken
	logic [`BP_PC_BIT-1:0] pc_bits;

	// Skip the byte offset
	assign pc_bits = lookup_pc[`BP_PC_BIT+1:2];

	// Combinational lookup against the speculative history
	assign lookup_idx   = ghist ^ pc_bits;
	assign lookup_hist  = ghist;
	assign lookup_taken = pht[lookup_idx];

	// History register
	always_ff @(posedge clock) begin
		if (reset) begin
			ghist <= '0;
		end else if (mispredict) begin
			// Roll back, then shift in what really happened
			ghist <= {fix_hist[`BP_GHT_BIT-2:0], fix_taken};
		end else if (lookup_fire) begin
			ghist <= {ghist[`BP_GHT_BIT-2:0], lookup_taken}; // Speculative
		end
	end

	// Pattern table is all not taken out of reset
	always_ff @(posedge clock) begin
		if (reset) begin
			pht <= '0;
		end else if (mispredict) begin
			pht[fix_idx] <= ~pht[fix_idx]; // Wrong guess flips the bit
		end
	end

	// Top holds lookups off while the queue repairs
	a_no_lookup_on_fix: assert property (@(posedge clock) disable iff (reset)
		!(lookup_fire && mispredict))
		else $error("Lookup fired in a mispredict cycle");

endmodule

// ==== src/outstanding_branch_queue.sv ====
// ======================================
// In-order queue of predicted branches
// Resolves oldest first; a mispredict empties it
// ======================================
`timescale 1ns/10ps
`include "bp_macros.svh"

module outstanding_branch_queue
	import bp_pkg::*;
(
	input  logic     clock,
	input  logic     reset,
	input  logic     push,          // Lookup fire
	input  pht_idx_t push_idx,
	input  ghist_t   push_hist,
	input  logic     push_taken,
	output logic     full,
	input  logic     resolve_valid, // Head branch resolves
	input  logic     resolve_taken,
	output logic     mispredict,
	output pht_idx_t fix_idx,
	output ghist_t   fix_hist,
	output logic     fix_taken
);

	localparam int unsigned DEPTH = `BP_OBQ_DEPTH;
	localparam int unsigned PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

	typedef logic [PTR_W-1:0] ptr_t;

	pht_idx_t         idx_mem [DEPTH];
	ghist_t           hist_mem [DEPTH];
	logic [DEPTH-1:0] taken_mem;
	ptr_t             wr_ptr;
	ptr_t             rd_ptr;
	obq_count_t       count;
	logic             empty;

	// Circular increment for any depth
	function automatic ptr_t ptr_next(input ptr_t ptr);
		if (ptr == ptr_t'(DEPTH - 1)) begin
			return '0;
		end
		return ptr + ptr_t'(1);
	endfunction

	assign full  = (count == obq_count_t'(DEPTH));
	assign empty = (count == '0);

	// Head compare is combinational so repair lands on the resolve edge
	assign mispredict = resolve_valid && (resolve_taken != taken_mem[rd_ptr]);
	assign fix_idx    = idx_mem[rd_ptr];
	assign fix_hist   = hist_mem[rd_ptr];
	assign fix_taken  = resolve_taken;

	always_ff @(posedge clock) begin
		if (reset) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else if (mispredict) begin
			// All younger branches are on the wrong path
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (push) begin
				wr_ptr <= ptr_next(wr_ptr);
			end
			if (resolve_valid) begin
				rd_ptr <= ptr_next(rd_ptr);
			end
			case ({push, resolve_valid})
				2'b10:   count <= count + obq_count_t'(1);
				2'b01:   count <= count - obq_count_t'(1);
				default: count <= count; // Both or neither
			endcase
		end
	end

	// Entry payload
	always_ff @(posedge clock) begin
		if (push) begin
			idx_mem[wr_ptr]   <= push_idx;
			hist_mem[wr_ptr]  <= push_hist;
			taken_mem[wr_ptr] <= push_taken;
		end
	end

	a_no_push_full: assert property (@(posedge clock) disable iff (reset)
		!(push && full))
		else $error("Push into a full branch queue");

	// Only branches already predicted may resolve
	a_no_resolve_empty: assert property (@(posedge clock) disable iff (reset)
		!(resolve_valid && empty))
		else $error("Resolve with no outstanding branch");

endmodule

// ==== src/prediction_output_stage.sv ====
// ======================================
// One-entry output register for guesses
// Holds PC and guess under back-pressure
// ======================================
`timescale 1ns/10ps

module prediction_output_stage
	import bp_pkg::*;
(
	input  logic clock,
	input  logic reset,
	input  logic flush,      // Drops the wrong-path guess
	input  logic load,       // Lookup fire
	input  pc_t  load_pc,
	input  logic load_taken,
	output logic can_load,
	output logic pred_valid,
	input  logic pred_ready,
	output pc_t  pred_pc,
	output logic pred_taken
);

	// Empty or the held entry leaves this cycle
	assign can_load = !pred_valid || pred_ready;

	always_ff @(posedge clock) begin
		if (reset) begin
			pred_valid <= 1'b0;
		end else if (flush) begin
			pred_valid <= 1'b0;
		end else if (load) begin
			pred_valid <= 1'b1;
		end else if (pred_ready) begin
			pred_valid <= 1'b0; // Delivered
		end
	end

	always_ff @(posedge clock) begin
		if (load) begin
			pred_pc    <= load_pc;
			pred_taken <= load_taken;
		end
	end

	// Payload must not move while fetch stalls
	a_hold_under_stall: assert property (@(posedge clock) disable iff (reset)
		pred_valid && !pred_ready && !flush |=>
			pred_valid && $stable(pred_pc) && $stable(pred_taken))
		else $error("Prediction changed under back-pressure");

endmodule

// ==== src/branch_predictor_top.sv ====
// ======================================
// Gshare direction predictor for fetch
// Resolves must be in order and already predicted
// ======================================
`timescale 1ns/10ps

module branch_predictor_top
	import bp_pkg::*;
(
	input  logic clock,
	input  logic reset,
	input  logic req_valid,
	output logic req_ready,
	input  pc_t  req_pc,
	output logic pred_valid,
	input  logic pred_ready,
	output pc_t  pred_pc,
	output logic pred_taken,
	input  logic resolve_valid,
	input  logic resolve_taken,
	output logic mispredict_flush  // Pulse when younger branches are dropped
);

	logic     stage_valid;
	pc_t      stage_pc;
	logic     lookup_fire;
	pht_idx_t lookup_idx;
	ghist_t   lookup_hist;
	logic     lookup_taken;
	logic     obq_full;
	logic     can_load;
	logic     mispredict;
	pht_idx_t fix_idx;
	ghist_t   fix_hist;
	logic     fix_taken;

	// Lookup needs a PC, queue room, output room and no repair
	assign lookup_fire      = stage_valid && !obq_full && can_load && !mispredict;
	assign mispredict_flush = mispredict;

	branch_request_stage i_request_stage (
		.clock       (clock),
		.reset       (reset),
		.flush       (mispredict),
		.req_valid   (req_valid),
		.req_pc      (req_pc),
		.req_ready   (req_ready),
		.stage_valid (stage_valid),
		.stage_pc    (stage_pc),
		.stage_take  (lookup_fire)
	);

	gshare_core i_gshare_core (
		.clock        (clock),
		.reset        (reset),
		.lookup_fire  (lookup_fire),
		.lookup_pc    (stage_pc),
		.lookup_idx   (lookup_idx),
		.lookup_hist  (lookup_hist),
		.lookup_taken (lookup_taken),
		.mispredict   (mispredict),
		.fix_idx      (fix_idx),
		.fix_hist     (fix_hist),
		.fix_taken    (fix_taken)
	);

	outstanding_branch_queue i_obq (
		.clock         (clock),
		.reset         (reset),
		.push          (lookup_fire),
		.push_idx      (lookup_idx),
		.push_hist     (lookup_hist),
		.push_taken    (lookup_taken),
		.full          (obq_full),
		.resolve_valid (resolve_valid),
		.resolve_taken (resolve_taken),
		.mispredict    (mispredict),
		.fix_idx       (fix_idx),
		.fix_hist      (fix_hist),
		.fix_taken     (fix_taken)
	);

	prediction_output_stage i_output_stage (
		.clock      (clock),
		.reset      (reset),
		.flush      (mispredict),
		.load       (lookup_fire),
		.load_pc    (stage_pc),
		.load_taken (lookup_taken),
		.can_load   (can_load),
		.pred_valid (pred_valid),
		.pred_ready (pred_ready),
		.pred_pc    (pred_pc),
		.pred_taken (pred_taken)
	);

endmodule

// ==== tests/tb_branch_predictor.sv ====
// ========================================
// Random fetch and resolve traffic checked against a gshare model
// Resolves only delivered branches, oldest first
// ========================================
`timescale 1ns/10ps
`include "bp_macros.svh"

module tb_branch_predictor
	import bp_pkg::*;
();

	localparam int N_REQ     = 3000;
	localparam int MAX_CYCLE = 20 * N_REQ; // Room for stalls and flushes
	localparam int PHT_SIZE  = 2 ** `BP_GHT_BIT;

	logic clock;
	logic reset;
	logic req_valid;
	logic req_ready;
	pc_t  req_pc;
	logic pred_valid;
	logic pred_ready;
	pc_t  pred_pc;
	logic pred_taken;
	logic resolve_valid;
	logic resolve_taken;
	logic mispredict_flush;

	logic [PHT_SIZE-1:0] model_pht;
	ghist_t      arch_hist;      // Resolved branches only
	pc_t         inflight_pc[$]; // Accepted but not delivered yet
	pc_t         open_pc[$];     // Delivered but not resolved yet
	logic        open_guess[$];
	int          errors;
	int          accepted;
	int          delivered;
	int          flushes;
	int          cycles;
	int          lone_age;       // Edges since a lone request or -1 when idle
	logic        hold_seen;      // Output stalled at the last sample
	pc_t         hold_pc;
	logic        hold_taken;
	int unsigned seed_val;

	branch_predictor_top i_dut (
		.clock            (clock),
		.reset            (reset),
		.req_valid        (req_valid),
		.req_ready        (req_ready),
		.req_pc           (req_pc),
		.pred_valid       (pred_valid),
		.pred_ready       (pred_ready),
		.pred_pc          (pred_pc),
		.pred_taken       (pred_taken),
		.resolve_valid    (resolve_valid),
		.resolve_taken    (resolve_taken),
		.mispredict_flush (mispredict_flush)
	);

	initial begin
		clock = 1'b0;
		forever #10 clock = ~clock;
	end

	always @(posedge clock) begin
		cycles++;
		if (cycles >= MAX_CYCLE) begin
			$display("Timeout: run did not finish within %0d cycles", MAX_CYCLE);
			$display("TEST RESULT: FAIL");
			$finish;
		end
	end

	task automatic report_error(input string msg);
		errors++;
		$display("Error at %0t ns: %s", $time, msg);
	endtask

	// Speculative history is the resolved one with every open guess shifted in
	function automatic logic model_guess(input pc_t pc);
		ghist_t spec;
		spec = arch_hist;
		foreach (open_guess[i]) begin
			spec = {spec[`BP_GHT_BIT-2:0], open_guess[i]};
		end
		return model_pht[spec ^ pc[`BP_PC_BIT+1:2]];
	endfunction

	task automatic retire_oldest(input logic outcome);
		pc_t      head_pc;
		pht_idx_t idx;
		head_pc = open_pc[0];
		idx     = arch_hist ^ head_pc[`BP_PC_BIT+1:2]; // Head snapshot is arch_hist
		if (outcome != open_guess[0]) begin
			model_pht[idx] = ~model_pht[idx]; // One-bit flip
		end
		arch_hist = {arch_hist[`BP_GHT_BIT-2:0], outcome};
		open_pc.delete(0);
		open_guess.delete(0);
	endtask

	task automatic drive_inputs(input logic allow_req);
		logic outcome;
		@(posedge clock);
		req_valid  <= allow_req && (($urandom % 100) < 60);
		req_pc     <= $urandom & ~32'h3; // Word aligned
		pred_ready <= ($urandom % 100) < 70;
		if (open_guess.size() > 0 && ($urandom % 100) < 40) begin
			outcome = (($urandom % 100) < 70) ? open_guess[0] : !open_guess[0];
			resolve_valid <= 1'b1;
			resolve_taken <= outcome;
		end else begin
			resolve_valid <= 1'b0;
			resolve_taken <= 1'b0;
		end
	endtask

	// Sample settled outputs, then apply the coming edge to the model
	task automatic check_cycle();
		logic exp_flush;
		logic exp_taken;
		@(negedge clock);
		if (lone_age >= 0) begin
			lone_age++;
			if (lone_age == 1 && pred_valid) begin
				report_error("prediction one edge after a lone request");
			end
			if (lone_age == 2) begin
				if (!pred_valid) begin
					report_error("no prediction two edges after a lone request");
				end
				lone_age = -1;
			end
		end
		if (hold_seen && (!pred_valid || pred_pc != hold_pc || pred_taken != hold_taken)) begin
			report_error("prediction changed while pred_ready was low");
		end
		if (open_guess.size() + int'(pred_valid) > `BP_OBQ_DEPTH) begin
			report_error("more branches outstanding than the queue holds");
		end
		exp_flush = 1'b0;
		if (resolve_valid) begin
			exp_flush = (resolve_taken != open_guess[0]);
		end
		if (mispredict_flush !== exp_flush) begin
			report_error($sformatf("mispredict_flush %0b, expected %0b",
				mispredict_flush, exp_flush));
		end
		hold_seen  = pred_valid && !pred_ready && !mispredict_flush;
		hold_pc    = pred_pc;
		hold_taken = pred_taken;
		if (exp_flush) begin
			retire_oldest(resolve_taken);
			open_pc.delete(); // Younger branches are wrong path
			open_guess.delete();
			inflight_pc.delete();
			lone_age = -1;
			flushes++;
		end else begin
			if (pred_valid && pred_ready) begin
				if (inflight_pc.size() == 0) begin
					report_error("prediction delivered with no request in flight");
				end else begin
					exp_taken = model_guess(inflight_pc[0]);
					if (pred_pc !== inflight_pc[0] || pred_taken !== exp_taken) begin
						report_error($sformatf("pc %h taken %0b, expected pc %h taken %0b",
							pred_pc, pred_taken, inflight_pc[0], exp_taken));
					end
					open_pc.push_back(inflight_pc[0]);
					open_guess.push_back(exp_taken);
					inflight_pc.delete(0);
					delivered++;
				end
			end
			if (resolve_valid) begin
				retire_oldest(resolve_taken);
			end
		end
		if (req_valid && req_ready) begin
			if (inflight_pc.size() == 0 && open_pc.size() < `BP_OBQ_DEPTH) begin
				lone_age = 0; // Nothing ahead so latency is fixed
			end
			inflight_pc.push_back(req_pc);
			accepted++;
		end
	endtask

	initial begin
		seed_val = 32'h9e0e_349e;
		void'($urandom(seed_val));
		reset         = 1'b1;
		req_valid     = 1'b0;
		req_pc        = '0;
		pred_ready    = 1'b0;
		resolve_valid = 1'b0;
		resolve_taken = 1'b0;
		errors        = 0;
		accepted      = 0;
		delivered     = 0;
		flushes       = 0;
		cycles        = 0;
		lone_age      = -1;
		hold_seen     = 1'b0;
		model_pht     = '0; // All not taken
		arch_hist     = '0;
		repeat (9) @(posedge clock);
		@(negedge clock);
		if (pred_valid || req_ready || mispredict_flush) begin
			report_error("outputs not low during reset");
		end
		@(posedge clock);
		reset <= 1'b0;
		while (accepted < N_REQ) begin
			drive_inputs(1'b1);
			check_cycle();
		end
		repeat (40) begin
			drive_inputs(1'b0); // Drain
			check_cycle();
		end
		$display("Summary: %0d accepted, %0d delivered, %0d flushes, %0d errors",
			accepted, delivered, flushes, errors);
		if (errors == 0) begin
			$display("TEST RESULT: PASS");
		end else begin
			$display("TEST RESULT: FAIL");
		end
		$finish;
	end

endmodule

// ==== list.f ====
+incdir+include
src/bp_pkg.sv
src/branch_request_stage.sv
src/gshare_core.sv
src/outstanding_branch_queue.sv
src/prediction_output_stage.sv
src/branch_predictor_top.sv
tests/tb_branch_predictor.sv
